// ==== Makefile ====
# Verilator build and run for the LSTM cell testbench

VERILATOR ?= verilator
TOP       ?= lstmCellTb
FILELIST  ?= lstmCell.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== lstmCell.f ====
+incdir+verification
source/lstmPkg.sv
source/gateUnit.sv
source/activationUnit.sv
source/elementwiseUnit.sv
source/lstmControl.sv
source/lstmCell.sv
verification/lstmCellTb.sv

// ==== source/activationUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module activationUnit
#(
    parameter bit isTanh = 1'b0
)
(
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           enable,
    input  logic [lstmPkg::layerWidth-1:0] operandVec,
    output logic [lstmPkg::layerWidth-1:0] resultVec
);
    import lstmPkg::*;

    logic signed [dataWidth-1:0] clampedWord [hiddenSize];

    // Hard tanh clamps to +-1 and hard sigmoid is x/4 + 0.5 clamped to 0..1
    always_comb
    begin
        logic signed [dataWidth-1:0] operandWord;
        logic signed [dataWidth-1:0] shaped;
        for (int h = 0; h < hiddenSize; h++)
        begin
            operandWord = operandVec[h*dataWidth +: dataWidth];
            if (isTanh)
                shaped = operandWord;
            else
                shaped = (operandWord >>> 2) + fixedHalf;
            if (shaped > fixedOne)
                clampedWord[h] = fixedOne;
            else if (isTanh && shaped < -fixedOne)
                clampedWord[h] = -fixedOne;
            else if (!isTanh && shaped < 0)
                clampedWord[h] = '0;
            else
                clampedWord[h] = shaped;
        end
    end

    always_ff @(posedge clock)
    begin
        for (int h = 0; h < hiddenSize; h++)
        begin
            if (reset || !enable)
                resultVec[h*dataWidth +: dataWidth] <= '0;
            else
                resultVec[h*dataWidth +: dataWidth] <= clampedWord[h];
        end
    end

    for (genvar h = 0; h < hiddenSize; h++)
    begin : rangeCheck
        assert property (@(posedge clock) disable iff (reset)
            $signed(resultVec[h*dataWidth +: dataWidth]) <= fixedOne &&
            $signed(resultVec[h*dataWidth +: dataWidth]) >= (isTanh ? -fixedOne : 18'sd0));
    end

endmodule

`default_nettype wire

// ==== source/elementwiseUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module elementwiseUnit
(
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           ziLoad,
    input  logic                           cfLoad,
    input  logic                           outputLoad,
    input  logic [1:0]                     stage,
    input  logic [lstmPkg::layerWidth-1:0] gateZ,
    input  logic [lstmPkg::layerWidth-1:0] gateI,
    input  logic [lstmPkg::layerWidth-1:0] gateF,
    input  logic [lstmPkg::layerWidth-1:0] gateO,
    input  logic [lstmPkg::layerWidth-1:0] sigmoidVec,
    input  logic [lstmPkg::layerWidth-1:0] tanhVec,
    output logic [lstmPkg::layerWidth-1:0] sigmoidOperand,
    output logic [lstmPkg::layerWidth-1:0] tanhOperand,
    output logic [lstmPkg::layerWidth-1:0] previousOutput
);
    import lstmPkg::*;

    logic [layerWidth-1:0] ziProduct;
    logic [layerWidth-1:0] cfProduct;
    logic [layerWidth-1:0] cellSum;
    logic [layerWidth-1:0] cellState;
    logic [layerWidth-1:0] multiplierA;
    logic [layerWidth-1:0] multiplierB;
    logic [layerWidth-1:0] productNext;
    logic [layerWidth-1:0] productVec;

    // Activation operands, tanh side is unused in stage B
    always_ff @(posedge clock)
    begin
        case (stage)
            stageB:
            begin
                sigmoidOperand <= gateF;
                tanhOperand <= '0;
            end
            stageC:
            begin
                sigmoidOperand <= gateO;
                tanhOperand <= cellSum;
            end
            default:
            begin
                sigmoidOperand <= gateI;
                tanhOperand <= gateZ;
            end
        endcase
    end

    // Stage B scales the stored cell state instead of a tanh result
    always_ff @(posedge clock)
    begin
        multiplierA <= (stage == stageB) ? cellState : tanhVec;
        multiplierB <= sigmoidVec;
        productVec <= productNext;
    end

    always_comb
    begin
        logic signed [productWidth-1:0] fullProduct;
        for (int h = 0; h < hiddenSize; h++)
        begin
            fullProduct = $signed(multiplierA[h*dataWidth +: dataWidth])
                * $signed(multiplierB[h*dataWidth +: dataWidth]);
            productNext[h*dataWidth +: dataWidth] = dataWidth'(fullProduct >>> fracBits);
            // Wraps on overflow
            cellSum[h*dataWidth +: dataWidth] = ziProduct[h*dataWidth +: dataWidth]
                + cfProduct[h*dataWidth +: dataWidth];
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            ziProduct <= '0;
            cfProduct <= '0;
            cellState <= '0;
            previousOutput <= '0;
        end
        else
        begin
            if (ziLoad)
                ziProduct <= productVec;
            if (cfLoad)
                cfProduct <= productVec;
            if (outputLoad)
            begin
                cellState <= cellSum;
                previousOutput <= productVec;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/gateUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module gateUnit
#(
    parameter logic [1:0] gateIndex = lstmPkg::gateZ
)
(
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           beginCalc,
    input  logic [lstmPkg::inputWidth-1:0] inputVec,
    input  logic [lstmPkg::layerWidth-1:0] previousOutput,
    output logic [lstmPkg::layerWidth-1:0] gateVec,
    output logic                           gateReady
);
    import lstmPkg::*;

    // Whole table for all four gates, this unit reads only its own row block
    logic signed [dataWidth-1:0] weightTable [4 * hiddenSize * rowLength];
    logic [$clog2(rowLength)-1:0] colCount;
    logic busy;
    logic signed [dataWidth-1:0] operandWord;
    logic signed [dataWidth-1:0] weightWord [hiddenSize];
    logic signed [productWidth-1:0] accumulator [hiddenSize];

    initial
    begin
        $readmemh(weightFile, weightTable);
    end

    // Columns run over the inputs, then the previous outputs, then the bias
    always_comb
    begin
        if (colCount < inputSize)
            operandWord = inputVec[colCount*dataWidth +: dataWidth];
        else if (colCount < inputSize + hiddenSize)
            operandWord = previousOutput[(colCount-inputSize)*dataWidth +: dataWidth];
        else
            operandWord = '0;
        for (int h = 0; h < hiddenSize; h++)
        begin
            weightWord[h] = weightTable[(gateIndex*hiddenSize + h)*rowLength + colCount];
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            colCount <= '0;
            gateReady <= 1'b0;
        end
        else
        begin
            gateReady <= 1'b0;
            if (beginCalc)
            begin
                busy <= 1'b1;
                colCount <= '0;
            end
            else if (busy)
            begin
                if (colCount == rowLength - 1)
                begin
                    busy <= 1'b0;
                    gateReady <= 1'b1;
                end
                else
                    colCount <= colCount + 1'b1;
            end
        end
    end

    // One product per hidden unit per cycle, bias added after the shift
    always_ff @(posedge clock)
    begin
        for (int h = 0; h < hiddenSize; h++)
        begin
            if (beginCalc)
                accumulator[h] <= '0;
            else if (busy && colCount != rowLength - 1)
                accumulator[h] <= accumulator[h] + weightWord[h] * operandWord;
            else if (busy)
                gateVec[h*dataWidth +: dataWidth] <=
                    dataWidth'(accumulator[h] >>> fracBits) + weightWord[h];
        end
    end

    // Control must not restart a gate that is still accumulating
    assert property (@(posedge clock) disable iff (reset)
        beginCalc |-> !busy);

endmodule

`default_nettype wire

// ==== source/lstmCell.sv ====
`timescale 1ns/1ns
`default_nettype none

module lstmCell
(
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           newSample,
    input  logic [lstmPkg::inputWidth-1:0] inputVec,
    output logic [lstmPkg::layerWidth-1:0] outputVec,
    output logic                           dataoutReady
);
    import lstmPkg::*;

    logic beginCalc;
    logic sigmoidEnable;
    logic tanhEnable;
    logic ziLoad;
    logic cfLoad;
    logic outputLoad;
    logic [1:0] stage;
    logic zGateReady;
    logic [layerWidth-1:0] zGate;
    logic [layerWidth-1:0] iGate;
    logic [layerWidth-1:0] fGate;
    logic [layerWidth-1:0] oGate;
    logic [layerWidth-1:0] sigmoidOperand;
    logic [layerWidth-1:0] tanhOperand;
    logic [layerWidth-1:0] sigmoidVec;
    logic [layerWidth-1:0] tanhVec;

    lstmControl control
    (
        .clock(clock),
        .reset(reset),
        .newSample(newSample),
        .gateReady(zGateReady),
        .beginCalc(beginCalc),
        .sigmoidEnable(sigmoidEnable),
        .tanhEnable(tanhEnable),
        .ziLoad(ziLoad),
        .cfLoad(cfLoad),
        .outputLoad(outputLoad),
        .stage(stage),
        .dataoutReady(dataoutReady)
    );

    // All four gates start together and finish in the same cycle
    gateUnit #(.gateIndex(gateZ)) zGateUnit
    (
        .clock(clock),
        .reset(reset),
        .beginCalc(beginCalc),
        .inputVec(inputVec),
        .previousOutput(outputVec),
        .gateVec(zGate),
        .gateReady(zGateReady)
    );

    gateUnit #(.gateIndex(gateI)) iGateUnit
    (
        .clock(clock),
        .reset(reset),
        .beginCalc(beginCalc),
        .inputVec(inputVec),
        .previousOutput(outputVec),
        .gateVec(iGate),
        .gateReady()
    );

    gateUnit #(.gateIndex(gateF)) fGateUnit
    (
        .clock(clock),
        .reset(reset),
        .beginCalc(beginCalc),
        .inputVec(inputVec),
        .previousOutput(outputVec),
        .gateVec(fGate),
        .gateReady()
    );

    gateUnit #(.gateIndex(gateO)) oGateUnit
    (
        .clock(clock),
        .reset(reset),
        .beginCalc(beginCalc),
        .inputVec(inputVec),
        .previousOutput(outputVec),
        .gateVec(oGate),
        .gateReady()
    );

    activationUnit #(.isTanh(1'b0)) sigmoidUnit
    (
        .clock(clock),
        .reset(reset),
        .enable(sigmoidEnable),
        .operandVec(sigmoidOperand),
        .resultVec(sigmoidVec)
    );

    activationUnit #(.isTanh(1'b1)) tanhUnit
    (
        .clock(clock),
        .reset(reset),
        .enable(tanhEnable),
        .operandVec(tanhOperand),
        .resultVec(tanhVec)
    );

    elementwiseUnit elementwise
    (
        .clock(clock),
        .reset(reset),
        .ziLoad(ziLoad),
        .cfLoad(cfLoad),
        .outputLoad(outputLoad),
        .stage(stage),
        .gateZ(zGate),
        .gateI(iGate),
        .gateF(fGate),
        .gateO(oGate),
        .sigmoidVec(sigmoidVec),
        .tanhVec(tanhVec),
        .sigmoidOperand(sigmoidOperand),
        .tanhOperand(tanhOperand),
        .previousOutput(outputVec)
    );

endmodule

`default_nettype wire

// ==== source/lstmControl.sv ====
`timescale 1ns/1ns
`default_nettype none

module lstmControl
(
    input  logic       clock,
    input  logic       reset,
    input  logic       newSample,
    input  logic       gateReady,
    output logic       beginCalc,
    output logic       sigmoidEnable,
    output logic       tanhEnable,
    output logic       ziLoad,
    output logic       cfLoad,
    output logic       outputLoad,
    output logic [1:0] stage,
    output logic       dataoutReady
);
    import lstmPkg::*;

    logic [3:0] state;
    logic [3:0] nextState;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= stateIdle;
            stage <= stageA;
        end
        else
        begin
            state <= nextState;
            if (state == stateGateInit)
                stage <= stageA;
            else if (state == stateProduct && stage == stageA)
                stage <= stageB;
            else if (state == stateProduct && stage == stageB)
                stage <= stageC;
        end
    end

    always_comb
    begin
        case (state)
            stateIdle:
                nextState = newSample ? stateGateInit : stateIdle;
            stateGateInit:
                nextState = stateGateCalc;
            stateGateCalc:
                nextState = gateReady ? stateActPipe : stateGateCalc;
            stateActPipe:
                nextState = stateAct1;
            stateAct1:
                nextState = stateAct2;
            stateAct2:
                nextState = stateProdPipe;
            stateProdPipe:
                nextState = stateProduct;
            // Stage C is the last pass through the element-wise states
            stateProduct:
                nextState = (stage == stageC) ? stateDone : stateActPipe;
            default:
                nextState = stateIdle;
        endcase
    end

    assign beginCalc = (state == stateGateInit);

    // The second activation cycle picks up an operand that changed on the first
    assign sigmoidEnable = (state == stateAct1) || (state == stateAct2);
    assign tanhEnable = sigmoidEnable && (stage != stageB);

    // Previous stage product is valid at the start of the next stage
    assign ziLoad = (state == stateActPipe) && (stage == stageB);
    assign cfLoad = (state == stateActPipe) && (stage == stageC);

    assign outputLoad = (state == stateDone);
    assign dataoutReady = (state == stateDone);

    // Completion is a single-cycle pulse
    assert property (@(posedge clock) disable iff (reset)
        dataoutReady |=> !dataoutReady);

    // Gate calculation only starts straight out of idle
    assert property (@(posedge clock) disable iff (reset)
        beginCalc |-> $past(state) == stateIdle);

endmodule

`default_nettype wire

// ==== source/lstmPkg.sv ====
`default_nettype none

package lstmPkg;

    // Q6.11 words with one sign bit
    localparam int fracBits = 11;
    localparam int intBits = 6;
    localparam int dataWidth = intBits + fracBits + 1;
    localparam int productWidth = 2 * dataWidth + 2;

    localparam int inputSize = 2;
    localparam int hiddenSize = 4;
    localparam int layerWidth = hiddenSize * dataWidth;
    localparam int inputWidth = inputSize * dataWidth;

    // Input weights, recurrent weights, then the bias
    localparam int rowLength = inputSize + hiddenSize + 1;

    localparam logic signed [dataWidth-1:0] fixedOne = 2048;
    localparam logic signed [dataWidth-1:0] fixedHalf = 1024;

    // Gate order, also the row block order in the weight file
    localparam logic [1:0] gateZ = 2'd0;
    localparam logic [1:0] gateI = 2'd1;
    localparam logic [1:0] gateF = 2'd2;
    localparam logic [1:0] gateO = 2'd3;

    localparam logic [1:0] stageA = 2'd0;
    localparam logic [1:0] stageB = 2'd1;
    localparam logic [1:0] stageC = 2'd2;

    localparam string weightFile = "source/weights.mem";

    // Control FSM, the element-wise states repeat once per stage
    localparam logic [3:0] stateIdle = 4'd0;
    localparam logic [3:0] stateGateInit = 4'd1;
    localparam logic [3:0] stateGateCalc = 4'd2;
    localparam logic [3:0] stateActPipe = 4'd3;
    localparam logic [3:0] stateAct1 = 4'd4;
    localparam logic [3:0] stateAct2 = 4'd5;
    localparam logic [3:0] stateProdPipe = 4'd6;
    localparam logic [3:0] stateProduct = 4'd7;
    localparam logic [3:0] stateDone = 4'd8;

endpackage

`default_nettype wire

// ==== source/weights.mem ====
// Per line: input weight 0, input weight 1, recurrent weights 0 to 3, bias
// Q6.11 in 18-bit hex, lines ordered gate Z, I, F, O then hidden unit
00666 3FCCD 0019A 3FF33 00200 3FE66 00000
3FB33 004CD 3FE00 00333 000CD 00100 000CD
00400 00333 00100 3FE66 3FF00 0019A 3FF33
3FCCD 3F99A 00333 000CD 3FE66 00200 0019A
004CD 0019A 000CD 3FF00 00200 3FE66 00100
3FE66 00666 00100 000CD 3FF33 00333 3FF00
00333 3FCCD 3FE66 00200 000CD 3FF33 00000
3FF33 00400 00200 3FE00 00100 000CD 0019A
00200 3FE66 000CD 00100 3FF33 000CD 00800
3FF33 00333 3FF00 000CD 00200 3FE66 00800
0019A 000CD 00333 3FF33 000CD 00100 00800
3FE66 3FF00 000CD 00200 3FE00 00333 00800
00333 00400 3FF33 000CD 00100 3FF00 000CD
3FCCD 0019A 00200 3FE66 000CD 00100 3FF33
00100 3FB33 000CD 00333 3FF00 0019A 00000
004CD 3FE66 3FF33 00100 00200 3FE00 0019A

// ==== verification/lstmModel.svh ====
`ifndef LSTM_MODEL_SVH
`define LSTM_MODEL_SVH

// Uses modelWeights, modelCell and modelOutput of the including module

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

task automatic loadWeights;
    $readmemh(weightFile, modelWeights);
endtask

// Q6.11 product, shifted back and cut to one word
function automatic logic signed [dataWidth-1:0] scaledProduct(
    input logic signed [dataWidth-1:0] a,
    input logic signed [dataWidth-1:0] b
);
    longint full;
    full = longint'(a) * longint'(b);
    return dataWidth'(full >>> fracBits);
endfunction

function automatic logic signed [dataWidth-1:0] hardSigmoid(
    input logic signed [dataWidth-1:0] x
);
    int shaped;
    shaped = (int'(x) >>> 2) + 1024;
    if (shaped > 2048)
        shaped = 2048;
    if (shaped < 0)
        shaped = 0;
    return dataWidth'(shaped);
endfunction

function automatic logic signed [dataWidth-1:0] hardTanh(
    input logic signed [dataWidth-1:0] x
);
    int shaped;
    shaped = int'(x);
    if (shaped > 2048)
        shaped = 2048;
    if (shaped < -2048)
        shaped = -2048;
    return dataWidth'(shaped);
endfunction

// Full-width sum, shift, then the bias
function automatic logic signed [dataWidth-1:0] gateValue(
    input int gate,
    input int h,
    input logic [inputWidth-1:0] inVec
);
    longint sum;
    int row;
    logic signed [dataWidth-1:0] operand;
    row = (gate * hiddenSize + h) * rowLength;
    sum = 0;
    for (int k = 0; k < inputSize + hiddenSize; k++)
    begin
        if (k < inputSize)
            operand = inVec[k*dataWidth +: dataWidth];
        else
            operand = modelOutput[k - inputSize];
        sum += longint'(modelWeights[row + k]) * longint'(operand);
    end
    return dataWidth'(sum >>> fracBits) + modelWeights[row + rowLength - 1];
endfunction

function automatic void modelStep(input logic [inputWidth-1:0] inVec);
    logic signed [dataWidth-1:0] zi;
    logic signed [dataWidth-1:0] cf;
    logic signed [dataWidth-1:0] nextOutput [hiddenSize];
    for (int h = 0; h < hiddenSize; h++)
    begin
        zi = scaledProduct(hardTanh(gateValue(0, h, inVec)),
            hardSigmoid(gateValue(1, h, inVec)));
        cf = scaledProduct(modelCell[h], hardSigmoid(gateValue(2, h, inVec)));
        // Cell state wraps like the hardware adder
        modelCell[h] = zi + cf;
        nextOutput[h] = scaledProduct(hardTanh(modelCell[h]),
            hardSigmoid(gateValue(3, h, inVec)));
    end
    for (int h = 0; h < hiddenSize; h++)
        modelOutput[h] = nextOutput[h];
endfunction

function automatic logic [layerWidth-1:0] packedOutput();
    logic [layerWidth-1:0] flat;
    for (int h = 0; h < hiddenSize; h++)
        flat[h*dataWidth +: dataWidth] = modelOutput[h];
    return flat;
endfunction

`endif

// ==== verification/lstmCellTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module lstmCellTb;
    import lstmPkg::*;

    // Gate calc, three stages of five cycles, completion and the edges around it
    localparam int sampleLatency = 2 + rowLength + 1 + 3 * 5 + 1;
    localparam int sampleCount = 20;
    localparam int cycleLimit = sampleCount * (sampleLatency + 8) + 100;
    localparam int saturated = 30 * 2048;

    logic clock;
    logic reset;
    logic newSample;
    logic [inputWidth-1:0] inputVec;
    logic [layerWidth-1:0] outputVec;
    logic dataoutReady;

    logic signed [dataWidth-1:0] modelWeights [4 * hiddenSize * rowLength];
    logic signed [dataWidth-1:0] modelCell [hiddenSize];
    logic signed [dataWidth-1:0] modelOutput [hiddenSize];
    logic [layerWidth-1:0] expectedOutput;
    logic [31:0] rngState;
    logic sampleSent;
    logic resultPending;
    int errorCount;
    int testErrors;
    int testCount;
    int samplesRun;
    int cycleCount;

    `include "lstmModel.svh"

    lstmCell dut_i
    (
        .clock(clock),
        .reset(reset),
        .newSample(newSample),
        .inputVec(inputVec),
        .outputVec(outputVec),
        .dataoutReady(dataoutReady)
    );

    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial
    begin
        cycleCount = 0;
        while (cycleCount < cycleLimit)
        begin
            @(posedge clock);
            cycleCount++;
        end
        $display("timeout: run did not complete within %0d cycles", cycleLimit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Nothing leaves the cell before the first sample
    assert property (@(posedge clock) disable iff (reset)
        !sampleSent |-> outputVec == '0)
    else
    begin
        errorCount++;
        $display("error: outputVec expected %h, got %h", {layerWidth{1'b0}},
            $sampled(outputVec));
    end

    // New output is visible the cycle after the pulse
    assert property (@(posedge clock) disable iff (reset)
        $past(dataoutReady) |-> outputVec == expectedOutput)
    else
    begin
        errorCount++;
        $display("error: outputVec expected %h, got %h", expectedOutput,
            $sampled(outputVec));
    end

    assert property (@(posedge clock) disable iff (reset)
        dataoutReady |=> !dataoutReady)
    else
    begin
        errorCount++;
        $display("dataoutReady stayed high for more than one cycle");
    end

    assert property (@(posedge clock) disable iff (reset)
        dataoutReady |-> resultPending)
    else
    begin
        errorCount++;
        $display("dataoutReady pulsed while no sample was pending");
    end

    // An accepted sample completes at the fixed latency, a restart would arrive late
    assert property (@(posedge clock) disable iff (reset)
        $rose(resultPending) |-> ##(sampleLatency - 1) dataoutReady)
    else
    begin
        errorCount++;
        $display("dataoutReady did not arrive at the fixed latency after newSample");
    end

    task automatic sendSample(input logic [inputWidth-1:0] sample);
        modelStep(sample);
        expectedOutput = packedOutput();
        inputVec = sample;
        newSample = 1'b1;
        sampleSent = 1'b1;
        resultPending = 1'b1;
        samplesRun++;
        @(posedge clock);
        #1;
        newSample = 1'b0;
    endtask

    task automatic awaitResult;
        while (!dataoutReady)
        begin
            @(posedge clock);
            #1;
        end
        // Pulse is sampled before the pending flag drops
        @(posedge clock);
        #1;
        resultPending = 1'b0;
        @(posedge clock);
        #1;
    endtask

    task automatic runSample(input logic [inputWidth-1:0] sample);
        sendSample(sample);
        awaitResult();
    endtask

    task automatic reportTest(input string name);
        testCount++;
        $display("test %0d %s: %0d errors", testCount, name, errorCount - testErrors);
        testErrors = errorCount;
    endtask

    // Each input within +-2.0
    function automatic logic [inputWidth-1:0] randomSample();
        logic [inputWidth-1:0] sample;
        for (int k = 0; k < inputSize; k++)
        begin
            rngState = xorshift32(rngState);
            sample[k*dataWidth +: dataWidth] = dataWidth'(int'(rngState % 32'd8193) - 4096);
        end
        return sample;
    endfunction

    function automatic logic [inputWidth-1:0] pairSample(input int first, input int second);
        return {dataWidth'(second), dataWidth'(first)};
    endfunction

    initial
    begin
        reset = 1'b1;
        newSample = 1'b0;
        inputVec = '0;
        expectedOutput = '0;
        sampleSent = 1'b0;
        resultPending = 1'b0;
        rngState = 32'h917f;
        errorCount = 0;
        testErrors = 0;
        testCount = 0;
        samplesRun = 0;
        loadWeights();
        for (int h = 0; h < hiddenSize; h++)
        begin
            modelCell[h] = '0;
            modelOutput[h] = '0;
        end
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        repeat (10) @(posedge clock);
        #1;
        reportTest("reset state");

        runSample(randomSample());
        reportTest("first sample");

        repeat (12) runSample(randomSample());
        reportTest("recurrent sequence");

        // Second pulse lands in the gate calculation
        sendSample(randomSample());
        repeat (5) @(posedge clock);
        #1;
        newSample = 1'b1;
        @(posedge clock);
        #1;
        newSample = 1'b0;
        awaitResult();
        repeat (sampleLatency + 4) @(posedge clock);
        #1;
        reportTest("ignored newSample");

        runSample(pairSample(saturated, saturated));
        runSample(pairSample(-saturated, -saturated));
        runSample(pairSample(saturated, -saturated));
        runSample(pairSample(-saturated, saturated));
        reportTest("saturation");

        $display("%0d tests, %0d samples, %0d errors", testCount, samplesRun, errorCount);
        if (errorCount == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
